/* files.f */
logic/xbus_pkg.sv
logic/xbus_map_pkg.sv
logic/xbus_if.sv
logic/xbus_ram.sv
logic/xbus_ctl.sv
logic/xbus_join.sv
logic/xbus_top.sv
sim/xbus_tb.sv

/* Bender.yml */
package:
  name: xbus_mem

sources:
  - logic/xbus_pkg.sv
  - logic/xbus_map_pkg.sv
  - logic/xbus_if.sv
  - logic/xbus_ram.sv
  - logic/xbus_ctl.sv
  - logic/xbus_join.sv
  - logic/xbus_top.sv
  - target: simulation
    files:
      - sim/xbus_tb.sv

/* sim/xbus_tb.sv */
// Xbus subsystem testbench
module xbus_tb
   import xbus_pkg::*, xbus_map_pkg::*;
();

   // expected latencies for the default build
   localparam int RAM_LAT = 3;
   localparam int CTL_LAT = 1;
   localparam int NXM_LAT = 4;
   localparam int DRAM_WORDS = 1 << 17;
   localparam int N_PAIRS = 16;

   // cycles per access, including the drop and the idle cycle
   localparam int RAM_COST = RAM_LAT + 1;
   localparam int CTL_COST = CTL_LAT + 1;
   localparam int NXM_COST = NXM_LAT + 1;
   localparam int EXPECTED_CYCLES = 4 + 2 * N_PAIRS * RAM_COST + 4 * RAM_COST
                                  + 7 * CTL_COST + 6 * CTL_COST + 20
                                  + 2 * RAM_COST + 2 * CTL_COST + 2 * NXM_COST;
   localparam int MAX_CYCLES = 20 * EXPECTED_CYCLES;

   logic       clk;
   logic       reset;
   xbus_addr_t addr;
   xbus_data_t datain;
   logic       req;
   logic       write;
   xbus_data_t dataout;
   logic       ack;
   logic       bus_error;

   int error_count = 0;
   int tests_passed = 0;
   int tests_failed = 0;
   int cycle_count = 0;

   xbus_top uut (
      .clk       (clk),
      .reset     (reset),
      .addr      (addr),
      .datain    (datain),
      .req       (req),
      .write     (write),
      .dataout   (dataout),
      .ack       (ack),
      .bus_error (bus_error)
   );

   always #5 clk = ~clk;

   // watchdog on the whole run
   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES)
      begin
         $display("run stopped after %0d cycles, a handshake never completed", MAX_CYCLES);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected)
      begin
         $display("** Error at %0t: %s is %h, expected %h", $time, name, got, expected);
         error_count++;
      end
   endtask

   // one request/ack cycle, entered and left just after a falling edge
   task automatic handshake(input logic wr, input xbus_addr_t a, input xbus_data_t d,
                            input int exp_lat, input logic exp_err,
                            output xbus_data_t rdata);
      int   cycles;
      logic err_seen;
      cycles = 0;
      err_seen = 1'b0;
      addr = a;
      datain = d;
      write = wr;
      req = 1'b1;
      do
      begin
         @(negedge clk);
         cycles++;
         err_seen = err_seen | bus_error;
      end
      while (!ack);
      rdata = dataout;
      req = 1'b0;
      write = 1'b0;
      check_value("ack latency", cycles, exp_lat);
      check_value("bus_error", err_seen, exp_err);
      // idle cycle before the next request
      @(negedge clk);
   endtask

   task automatic bus_write(input xbus_addr_t a, input xbus_data_t d,
                            input int exp_lat, input logic exp_err);
      xbus_data_t unused;
      handshake(1'b1, a, d, exp_lat, exp_err, unused);
   endtask

   task automatic bus_read(input xbus_addr_t a, output xbus_data_t d,
                           input int exp_lat, input logic exp_err);
      handshake(1'b0, a, '0, exp_lat, exp_err, d);
   endtask

   task automatic finish_test(input string name, input int errors_before);
      int errs;
      errs = error_count - errors_before;
      $display("test %s done, %0d mismatches", name, errs);
      if (errs == 0)
         tests_passed++;
      else
         tests_failed++;
   endtask

   task automatic ram_readback();
      xbus_data_t model [xbus_addr_t];
      xbus_addr_t addrs [$];
      xbus_addr_t a;
      xbus_data_t d;
      int         errs;
      errs = error_count;
      for (int i = 0; i < N_PAIRS; i++)
      begin
         a = xbus_addr_t'($urandom % DRAM_WORDS);
         d = $urandom;
         model[a] = d;
         addrs.push_back(a);
         bus_write(a, d, RAM_LAT, 1'b0);
      end
      // later writes to a repeated address win
      foreach (addrs[i])
      begin
         bus_read(addrs[i], d, RAM_LAT, 1'b0);
         check_value("ram dataout", d, model[addrs[i]]);
      end
      finish_test("ram read-back", errs);
   endtask

   task automatic ram_unimplemented();
      xbus_addr_t lo;
      xbus_addr_t hi;
      xbus_data_t lo_word;
      xbus_data_t d;
      int         errs;
      errs = error_count;
      lo = xbus_addr_t'($urandom % DRAM_WORDS);
      hi = lo | xbus_addr_t'(DRAM_WORDS);
      lo_word = $urandom;
      bus_write(lo, lo_word, RAM_LAT, 1'b0);
      bus_write(hi, ~lo_word, RAM_LAT, 1'b0);
      bus_read(lo, d, RAM_LAT, 1'b0);
      check_value("ram aliased dataout", d, lo_word);
      bus_read(hi, d, RAM_LAT, 1'b0);
      check_value("ram unimplemented dataout", d, 32'hffff_ffff);
      finish_test("ram unimplemented region", errs);
   endtask

   task automatic ctl_scratch();
      xbus_data_t word;
      xbus_data_t d;
      int         errs;
      errs = error_count;
      word = $urandom;
      bus_write(CTL_BASE, word, CTL_LAT, 1'b0);
      bus_read(CTL_BASE, d, CTL_LAT, 1'b0);
      check_value("scratch dataout", d, word);
      for (int off = 3; off < 8; off++)
      begin
         bus_read(CTL_BASE | xbus_addr_t'(off), d, CTL_LAT, 1'b0);
         check_value("unused register dataout", d, 32'h0);
      end
      finish_test("control scratch", errs);
   endtask

   task automatic interval_timer();
      xbus_addr_t timer_addr;
      xbus_addr_t status_addr;
      xbus_data_t d;
      int         errs;
      errs = error_count;
      timer_addr = CTL_BASE | xbus_addr_t'(CTL_TIMER);
      status_addr = CTL_BASE | xbus_addr_t'(CTL_STATUS);
      bus_write(timer_addr, 32'd10, CTL_LAT, 1'b0);
      bus_read(status_addr, d, CTL_LAT, 1'b0);
      check_value("status bit 0 while counting", d[0], 1'b0);
      repeat (20) @(negedge clk);
      bus_read(status_addr, d, CTL_LAT, 1'b0);
      check_value("status bit 0 after expiry", d[0], 1'b1);
      bus_read(timer_addr, d, CTL_LAT, 1'b0);
      check_value("timer dataout after expiry", d, 32'h0);
      bus_write(status_addr, 32'h0, CTL_LAT, 1'b0);
      bus_read(status_addr, d, CTL_LAT, 1'b0);
      check_value("status bit 0 after clear", d[0], 1'b0);
      finish_test("interval timer", errs);
   endtask

   task automatic nonexistent_memory();
      xbus_addr_t nxm_addr;
      xbus_addr_t ram_addr;
      xbus_data_t ram_word;
      xbus_data_t scratch_word;
      xbus_data_t d;
      int         errs;
      errs = error_count;
      // low bits alias both a ram word and the scratch offset
      nxm_addr = RAM_DECODE_LIMIT + 22'h100;
      ram_addr = 22'h100;
      ram_word = $urandom;
      scratch_word = $urandom;
      bus_write(ram_addr, ram_word, RAM_LAT, 1'b0);
      bus_write(CTL_BASE, scratch_word, CTL_LAT, 1'b0);
      bus_read(nxm_addr, d, NXM_LAT, 1'b1);
      check_value("nxm dataout", d, 32'hffff_ffff);
      bus_write(nxm_addr, ~ram_word, NXM_LAT, 1'b1);
      bus_read(ram_addr, d, RAM_LAT, 1'b0);
      check_value("ram dataout after nxm write", d, ram_word);
      bus_read(CTL_BASE, d, CTL_LAT, 1'b0);
      check_value("scratch dataout after nxm write", d, scratch_word);
      finish_test("nonexistent memory", errs);
   endtask

   initial
   begin
      clk = 1'b0;
      reset = 1'b1;
      addr = '0;
      datain = '0;
      req = 1'b0;
      write = 1'b0;
      void'($urandom(32'h3bc41e25));
      repeat (3) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);

      ram_readback();
      ram_unimplemented();
      ctl_scratch();
      interval_timer();
      nonexistent_memory();

      $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
      if (error_count == 0 && tests_failed == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

/* logic/xbus_top.sv */
// Xbus memory subsystem
module xbus_top
   import xbus_pkg::*;
#(
   parameter int DRAM_BITS   = 17,
   parameter int ACK_DELAY   = 2,
   parameter int NXM_TIMEOUT = 4
)
(
   input  logic       clk,
   input  logic       reset,
   input  xbus_addr_t addr,
   input  xbus_data_t datain,
   input  logic       req,
   input  logic       write,
   output xbus_data_t dataout,
   output logic       ack,
   output logic       bus_error
);

   // one connection per slave
   xbus_if ram_bus ();
   xbus_if ctl_bus ();

   xbus_join #(
      .NXM_TIMEOUT (NXM_TIMEOUT)
   ) join_i (
      .clk       (clk),
      .reset     (reset),
      .addr      (addr),
      .datain    (datain),
      .req       (req),
      .write     (write),
      .dataout   (dataout),
      .ack       (ack),
      .bus_error (bus_error),
      .ram       (ram_bus.master),
      .ctl       (ctl_bus.master)
   );

   xbus_ram #(
      .DRAM_BITS (DRAM_BITS),
      .ACK_DELAY (ACK_DELAY)
   ) ram_i (
      .clk   (clk),
      .reset (reset),
      .bus   (ram_bus.slave)
   );

   xbus_ctl ctl_i (
      .clk   (clk),
      .reset (reset),
      .bus   (ctl_bus.slave)
   );

endmodule

/* logic/xbus_join.sv */
// Xbus slave join
module xbus_join
   import xbus_pkg::*;
#(
   parameter int NXM_TIMEOUT = 4
)
(
   input  logic       clk,
   input  logic       reset,
   input  xbus_addr_t addr,
   input  xbus_data_t datain,
   input  logic       req,
   input  logic       write,
   output xbus_data_t dataout,
   output logic       ack,
   output logic       bus_error,
   xbus_if.master     ram,
   xbus_if.master     ctl
);

   localparam int CNT_W = $clog2(NXM_TIMEOUT + 1);

   logic [CNT_W-1:0] nxm_count;
   logic             nxm_ack;
   logic             any_decode;

   // same request to every slave, each decodes for itself
   assign ram.addr   = addr;
   assign ram.datain = datain;
   assign ram.write  = write;
   assign ram.req    = req;

   assign ctl.addr   = addr;
   assign ctl.datain = datain;
   assign ctl.write  = write;
   assign ctl.req    = req;

   assign any_decode = ram.decode | ctl.decode;

   // nonexistent memory timeout
   // counter saturates so a held req gets one ack only
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         nxm_count <= '0;
         nxm_ack   <= 1'b0;
      end
      else if (!req)
      begin
         nxm_count <= '0;
         nxm_ack   <= 1'b0;
      end
      else
      begin
         if (!any_decode && nxm_count != CNT_W'(NXM_TIMEOUT))
            nxm_count <= nxm_count + 1'b1;
         nxm_ack <= ~any_decode & (nxm_count == CNT_W'(NXM_TIMEOUT - 1));
      end
   end

   // ram first, then control, then the timeout path
   always_comb
   begin
      if (ram.decode)
      begin
         ack     = ram.ack;
         dataout = ram.dataout;
      end
      else if (ctl.decode)
      begin
         ack     = ctl.ack;
         dataout = ctl.dataout;
      end
      else
      begin
         ack     = nxm_ack;
         dataout = XBUS_NXM_DATA;
      end
   end

   assign bus_error = nxm_ack & ~any_decode;

endmodule

/* logic/xbus_ctl.sv */
// Xbus control registers
module xbus_ctl
   import xbus_pkg::*, xbus_map_pkg::*;
(
   input logic   clk,
   input logic   reset,
   xbus_if.slave bus
);

   xbus_data_t scratch;
   xbus_data_t timer;
   logic       expired;

   logic       ack_q;
   logic       served;
   logic       start;
   logic       wr_scratch;
   logic       wr_timer;
   logic       wr_status;
   ctl_reg_e   reg_sel;

   // eight words at the control base
   assign bus.decode = (bus.addr[XBUS_ADDR_W-1:CTL_SPAN_BITS] ==
                        CTL_BASE[XBUS_ADDR_W-1:CTL_SPAN_BITS]);

   assign reg_sel = ctl_reg_e'(bus.addr[CTL_SPAN_BITS-1:0]);

   // take each request once, even if req is held past ack
   assign start = bus.req & bus.decode & ~ack_q & ~served;

   assign wr_scratch = start & bus.write & (reg_sel == CTL_SCRATCH);
   assign wr_timer   = start & bus.write & (reg_sel == CTL_TIMER);
   assign wr_status  = start & bus.write & (reg_sel == CTL_STATUS);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ack_q  <= 1'b0;
         served <= 1'b0;
      end
      else
      begin
         ack_q  <= start;
         // held until req drops
         served <= bus.req & (served | ack_q);
      end
   end

   assign bus.ack = ack_q;

   always_ff @(posedge clk)
   begin
      if (reset)
         scratch <= '0;
      else if (wr_scratch)
         scratch <= bus.datain;
   end

   // interval timer, counts down to zero and flags expiry
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         timer   <= '0;
         expired <= 1'b0;
      end
      else if (wr_timer)
      begin
         timer   <= bus.datain;
         expired <= 1'b0;
      end
      else
      begin
         if (timer != '0)
            timer <= timer - 1'b1;
         // a status write wins over a flag set in the same cycle
         if (wr_status)
            expired <= 1'b0;
         else if (timer == xbus_data_t'(1))
            expired <= 1'b1;
      end
   end

   always_comb
   begin
      case (reg_sel)
         CTL_SCRATCH: bus.dataout = scratch;
         CTL_TIMER:   bus.dataout = timer;
         CTL_STATUS:  bus.dataout = {{(XBUS_DATA_W-1){1'b0}}, expired};
         default:     bus.dataout = '0;
      endcase
   end

endmodule

/* logic/xbus_ram.sv */
// Xbus RAM slave
module xbus_ram
   import xbus_pkg::*, xbus_map_pkg::*;
#(
   parameter int DRAM_BITS = 17,
   parameter int ACK_DELAY = 2
)
(
   input logic   clk,
   input logic   reset,
   xbus_if.slave bus
);

   localparam int RAM_WORDS = 1 << DRAM_BITS;

   xbus_data_t mem [RAM_WORDS];

   logic                 req_delayed;
   logic [ACK_DELAY-1:0] ack_stages;
   logic                 busy;
   logic                 in_range;
   logic [DRAM_BITS-1:0] word_addr;

   // decoded up to the limit, but only the low part is backed by memory
   assign bus.decode = (bus.addr < RAM_DECODE_LIMIT);
   assign in_range   = ((bus.addr >> DRAM_BITS) == '0);
   assign word_addr  = bus.addr[DRAM_BITS-1:0];

   // one access in flight at a time
   assign busy = req_delayed | (|ack_stages);

   assign bus.ack = ack_stages[ACK_DELAY-1];

   // acknowledge chain, seeded one cycle after the request is taken
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         req_delayed <= 1'b0;
         ack_stages  <= '0;
      end
      else
      begin
         req_delayed   <= bus.req & bus.decode & ~busy;
         ack_stages[0] <= req_delayed;
         for (int i = 1; i < ACK_DELAY; i++)
         begin
            ack_stages[i] <= ack_stages[i-1];
         end
      end
   end

   // write lands while the chain is being seeded
   // addresses past the implemented size are dropped
   always_ff @(posedge clk)
   begin
      if (bus.req & bus.decode & req_delayed & bus.write & in_range)
      begin
         mem[word_addr] <= bus.datain;
      end
   end

   // read data follows the address, valid by the time ack rises
   assign bus.dataout = in_range ? mem[word_addr] : XBUS_NXM_DATA;

endmodule

/* logic/xbus_if.sv */
// Xbus slave connection
interface xbus_if
   import xbus_pkg::*;
   ();

   // request side, from the join
   xbus_addr_t addr;
   xbus_data_t datain;
   logic       write;
   logic       req;

   // response side, from the slave
   xbus_data_t dataout;
   logic       ack;
   logic       decode;

   modport master (
      output addr,
      output datain,
      output write,
      output req,
      input  dataout,
      input  ack,
      input  decode
   );

   modport slave (
      input  addr,
      input  datain,
      input  write,
      input  req,
      output dataout,
      output ack,
      output decode
   );

endinterface

/* logic/xbus_map_pkg.sv */
// Xbus address map
package xbus_map_pkg;

   import xbus_pkg::*;

   // ram decodes everything below this word address
   localparam xbus_addr_t RAM_DECODE_LIMIT = 22'o11000000;

   // control block, eight words
   localparam xbus_addr_t CTL_BASE = 22'o17773000;
   localparam int CTL_SPAN_BITS = 3;

   // register offsets within the control block
   // offsets 3 to 7 are unused and read zero
   typedef enum logic [CTL_SPAN_BITS-1:0] {
      CTL_SCRATCH = 3'd0,
      CTL_TIMER   = 3'd1,
      CTL_STATUS  = 3'd2
   } ctl_reg_e;

endpackage

/* logic/xbus_pkg.sv */
// Xbus common types
package xbus_pkg;

   // word address and data widths
   localparam int XBUS_ADDR_W = 22;
   localparam int XBUS_DATA_W = 32;

   // a bus word address
   typedef logic [XBUS_ADDR_W-1:0] xbus_addr_t;

   // a bus data word
   typedef logic [XBUS_DATA_W-1:0] xbus_data_t;

   // returned for locations with nothing behind them,
   // both nonexistent memory and ram above the implemented size
   localparam xbus_data_t XBUS_NXM_DATA = '1;

endpackage
